/* build.f */
lpc_sniffer_pkg.sv
lpc_cycle_fsm.sv
lpc_nibble_shifter.sv
lpc_port_filter.sv
lpc_record_fifo.sv
lpc_sniffer_top.sv
tb_lpc_sniffer.sv

/* lpc_cycle_fsm.sv */
// lpc frame decoder
// follows each host cycle phase by phase and strobes the nibble shifter,
// commits finished i/o cycles and aborts restarted or failed ones
`timescale 1ns/10ps
`default_nettype none

module lpc_cycle_fsm import lpc_sniffer_pkg::*; (
	input  wire logic       lpc_clock,
	input  wire logic       lpc_reset,   // async, active low
	input  wire logic [3:0] lpc_ad,
	input  wire logic       lpc_frame,   // active low
	output logic            shift_addr,
	output logic            shift_wdata,
	output logic            shift_rdata,
	output logic            set_dir,
	output logic            commit,
	output logic            abort
);

	lpc_state_e state;
	logic [1:0] cnt;       // nibble counter for addr, data and tar
	logic       is_read;   // direction of the cycle in flight
	lpc_cyc_e   cyc;
	logic       cyc_ok;
	logic       sync_wait;
	logic       sync_good;
	logic       done;

	assign cyc = lpc_cyc_e'(lpc_ad);
	assign cyc_ok = (cyc == cyc_io_read) || (cyc == cyc_io_write); // mem, dma, fwh dropped

	assign sync_wait = (lpc_ad == lpc_sync_long_wait) || (lpc_ad == lpc_sync_short_wait);
	assign sync_good = (lpc_ad == lpc_sync_ready);

	// completion edge is a good sync on a write or the last data nibble on a read
	assign done = lpc_frame && (
		(state == st_sync && sync_good && !is_read) ||
		(state == st_rdata && cnt == 2'd1));

	// strobes act on the nibble sampled at this edge
	assign shift_addr  = lpc_frame && (state == st_addr);
	assign shift_wdata = lpc_frame && (state == st_wdata);
	assign shift_rdata = lpc_frame && (state == st_rdata);
	assign set_dir     = lpc_frame && (state == st_cyctype) && cyc_ok;

	// restart or any frame low mid-cycle, or a bad sync code
	// error sync 1010 lands here as well
	assign abort = (!lpc_frame && state != st_idle) ||
		(lpc_frame && state == st_sync && !sync_good && !sync_wait);

	always_ff @(posedge lpc_clock or negedge lpc_reset) begin
		if (!lpc_reset) begin
			state   <= st_idle;
			cnt     <= 2'd0;
			is_read <= 1'b0;
			commit  <= 1'b0;
		end else begin
			commit <= done; // one cycle after the completion edge
			if (!lpc_frame) begin
				cnt <= 2'd0;
				if (lpc_ad == lpc_start_nibble)
					state <= st_cyctype; // start from any state
				else
					state <= st_idle;
			end else begin
				case (state)
					st_idle: begin
						cnt <= 2'd0;
					end
					st_cyctype: begin
						cnt <= 2'd0;
						if (cyc_ok) begin
							is_read <= (cyc == cyc_io_read);
							state   <= st_addr;
						end else begin
							state <= st_idle; // unsupported type
						end
					end
					st_addr: begin
						cnt <= cnt + 2'd1;
						if (cnt == 2'd3) // four nibbles, high first
							state <= is_read ? st_tar1 : st_wdata;
					end
					st_wdata: begin
						if (cnt == 2'd1) begin
							cnt   <= 2'd0;
							state <= st_tar1;
						end else begin
							cnt <= cnt + 2'd1;
						end
					end
					st_tar1: begin
						if (cnt == 2'd1) begin
							cnt   <= 2'd0;
							state <= st_sync;
						end else begin
							cnt <= cnt + 2'd1;
						end
					end
					st_sync: begin
						cnt <= 2'd0;
						if (sync_good)
							state <= is_read ? st_rdata : st_idle;
						else if (!sync_wait)
							state <= st_idle; // error or unknown sync
					end
					st_rdata: begin
						if (cnt == 2'd1) begin
							cnt   <= 2'd0;
							state <= st_tar2;
						end else begin
							cnt <= cnt + 2'd1;
						end
					end
					st_tar2: begin
						if (cnt == 2'd1) begin
							cnt   <= 2'd0;
							state <= st_idle;
						end else begin
							cnt <= cnt + 2'd1;
						end
					end
					default: begin
						cnt   <= 2'd0;
						state <= st_idle;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* lpc_nibble_shifter.sv */
// lpc nibble assembler
// builds port, data and direction of the current cycle from lpc_ad
`timescale 1ns/10ps
`default_nettype none

module lpc_nibble_shifter import lpc_sniffer_pkg::*; (
	input  wire logic       lpc_clock,
	input  wire logic       lpc_reset,
	input  wire logic [3:0] lpc_ad,
	input  wire logic       shift_addr,
	input  wire logic       shift_wdata,
	input  wire logic       shift_rdata,
	input  wire logic       set_dir,
	input  wire logic       commit,
	input  wire logic       abort,
	output lpc_record_t     cur_rec,
	output logic            commit_out
);

	// record is complete and quiet while commit is high
	assign commit_out = commit;

	always_ff @(posedge lpc_clock or negedge lpc_reset) begin
		if (!lpc_reset) begin
			cur_rec <= '0;
		end else if (abort) begin
			cur_rec <= '0; // drop partial record
		end else begin
			if (set_dir)
				cur_rec.is_write <= lpc_ad[1]; // 0010 is io write
			if (shift_addr)
				cur_rec.port <= {cur_rec.port[11:0], lpc_ad}; // high nibble first
			if (shift_wdata || shift_rdata)
				cur_rec.data <= {lpc_ad, cur_rec.data[7:4]}; // low nibble first
		end
	end

endmodule

`default_nettype wire

/* lpc_port_filter.sv */
// port window filter
// registers committed records and forwards those inside the window
`timescale 1ns/10ps
`default_nettype none

module lpc_port_filter import lpc_sniffer_pkg::*; #(
	parameter logic [15:0] PORT_BASE = 16'h0080,
	parameter logic [15:0] PORT_MASK = 16'hfff8
) (
	input  wire logic         lpc_clock,
	input  wire logic         lpc_reset,
	input  wire logic         commit_in,
	input  wire lpc_record_t  in_rec,
	output logic              push,
	output lpc_record_t       push_rec
);

	logic hit;

	assign hit = (in_rec.port & PORT_MASK) == (PORT_BASE & PORT_MASK);

	always_ff @(posedge lpc_clock or negedge lpc_reset) begin
		if (!lpc_reset)
			push <= 1'b0;
		else
			push <= commit_in && hit; // out of window just vanishes
	end

	always_ff @(posedge lpc_clock) begin
		if (commit_in)
			push_rec <= in_rec;
	end

endmodule

`default_nettype wire

/* lpc_record_fifo.sv */
// record queue
// circular buffer with valid/ready drain and a saturating drop counter
`timescale 1ns/10ps
`default_nettype none

module lpc_record_fifo import lpc_sniffer_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  wire logic         lpc_clock,
	input  wire logic         lpc_reset,
	input  wire logic         push,
	input  wire lpc_record_t  push_rec,
	input  wire logic         rec_ready,
	output logic              rec_valid,
	output lpc_record_t       rec,
	output logic [7:0]        drop_count
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	lpc_record_t      mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;   // occupancy
	logic             full;
	logic             do_push;
	logic             do_pop;

	assign full      = (count == CNT_W'(FIFO_DEPTH));
	assign rec_valid = (count != '0);
	assign rec       = mem[rd_ptr]; // head holds until popped
	assign do_pop    = rec_valid && rec_ready;
	assign do_push   = push && (!full || do_pop); // pop frees a slot this edge

	always_ff @(posedge lpc_clock) begin
		if (do_push)
			mem[wr_ptr] <= push_rec;
	end

	always_ff @(posedge lpc_clock or negedge lpc_reset) begin
		if (!lpc_reset) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			drop_count <= 8'd0;
		end else begin
			if (do_push) begin
				if (wr_ptr == PTR_W'(FIFO_DEPTH - 1))
					wr_ptr <= '0; // wrap
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				if (rd_ptr == PTR_W'(FIFO_DEPTH - 1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
			if (push && !do_push && drop_count != 8'hff)
				drop_count <= drop_count + 8'd1; // saturates at 255
		end
	end

endmodule

`default_nettype wire

/* lpc_sniffer_pkg.sv */
// lpc snooper shared definitions
// bus nibble codes, decoder phases, cycle types and the record format
`default_nettype none

package lpc_sniffer_pkg;

	// nibble codes seen on lpc_ad
	localparam logic [3:0] lpc_start_nibble    = 4'b0000; // with lpc_frame low
	localparam logic [3:0] lpc_sync_ready      = 4'b0000;
	localparam logic [3:0] lpc_sync_long_wait  = 4'b0110;
	localparam logic [3:0] lpc_sync_short_wait = 4'b0101;
	localparam logic [3:0] lpc_sync_error      = 4'b1010;

	// frame phase of the decoder
	typedef enum logic [2:0] {
		st_idle,
		st_cyctype,
		st_addr,
		st_wdata,
		st_tar1,
		st_sync,
		st_rdata,
		st_tar2
	} lpc_state_e;

	// cycle type and direction, as in the lpc spec
	typedef enum logic [3:0] {
		cyc_io_read  = 4'b0000,
		cyc_io_write = 4'b0010
	} lpc_cyc_e;

	// one decoded i/o cycle
	typedef struct packed {
		logic        is_write;
		logic [15:0] port;
		logic [7:0]  data;
	} lpc_record_t;

endpackage

`default_nettype wire

/* lpc_sniffer_top.sv */
// lpc i/o cycle snooper
// decodes host i/o reads and writes, filters by port window and queues records
`timescale 1ns/10ps
`default_nettype none

module lpc_sniffer_top import lpc_sniffer_pkg::*; #(
	parameter logic [15:0] PORT_BASE  = 16'h0080,
	parameter logic [15:0] PORT_MASK  = 16'hfff8,
	parameter int          FIFO_DEPTH = 4
) (
	input  wire logic       lpc_clock,
	input  wire logic       lpc_reset,   // async, active low
	input  wire logic [3:0] lpc_ad,
	input  wire logic       lpc_frame,   // active low
	input  wire logic       rec_ready,
	output logic            rec_valid,
	output lpc_record_t     rec,
	output logic [7:0]      drop_count
);

	logic        shift_addr;
	logic        shift_wdata;
	logic        shift_rdata;
	logic        set_dir;
	logic        commit;
	logic        abort;
	logic        commit_out;
	lpc_record_t cur_rec;
	logic        push;
	lpc_record_t push_rec;

	lpc_cycle_fsm u_lpc_cycle_fsm (
		.lpc_clock   (lpc_clock),
		.lpc_reset   (lpc_reset),
		.lpc_ad      (lpc_ad),
		.lpc_frame   (lpc_frame),
		.shift_addr  (shift_addr),
		.shift_wdata (shift_wdata),
		.shift_rdata (shift_rdata),
		.set_dir     (set_dir),
		.commit      (commit),
		.abort       (abort)
	);

	lpc_nibble_shifter u_lpc_nibble_shifter (
		.lpc_clock   (lpc_clock),
		.lpc_reset   (lpc_reset),
		.lpc_ad      (lpc_ad),
		.shift_addr  (shift_addr),
		.shift_wdata (shift_wdata),
		.shift_rdata (shift_rdata),
		.set_dir     (set_dir),
		.commit      (commit),
		.abort       (abort),
		.cur_rec     (cur_rec),
		.commit_out  (commit_out)
	);

	lpc_port_filter #(
		.PORT_BASE (PORT_BASE),
		.PORT_MASK (PORT_MASK)
	) u_lpc_port_filter (
		.lpc_clock (lpc_clock),
		.lpc_reset (lpc_reset),
		.commit_in (commit_out),
		.in_rec    (cur_rec),
		.push      (push),
		.push_rec  (push_rec)
	);

	lpc_record_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_lpc_record_fifo (
		.lpc_clock  (lpc_clock),
		.lpc_reset  (lpc_reset),
		.push       (push),
		.push_rec   (push_rec),
		.rec_ready  (rec_ready),
		.rec_valid  (rec_valid),
		.rec        (rec),
		.drop_count (drop_count)
	);

endmodule

`default_nettype wire

/* tb_lpc_sniffer.sv */
// lpc snooper testbench
// a host bus model drives i/o, memory and broken cycles
// and assertions check the record port against a scoreboard queue
`timescale 1ns/10ps
`default_nettype none

module tb_lpc_sniffer import lpc_sniffer_pkg::*; ();

	localparam int          FIFO_DEPTH      = 4;
	localparam int          MAX_FRAMES      = 40;
	localparam int          FRAME_CYCLES    = 20;   // longest frame incl. gap
	localparam int          WATCHDOG_CYCLES = MAX_FRAMES * FRAME_CYCLES * 3 / 2;
	localparam logic [15:0] WIN_BASE        = 16'h0080;
	localparam logic [15:0] WIN_MASK        = 16'hfff8;

	logic        lpc_clock;
	logic        lpc_reset;
	logic [3:0]  lpc_ad;
	logic        lpc_frame;
	logic        rec_ready;
	logic        rec_valid;
	lpc_record_t rec;
	logic [7:0]  drop_count;

	lpc_record_t exp_q[$];      // scoreboard, bus order
	int          errors;
	int          tests;
	int          test_err0;     // error count when the test began
	int          model_drops;
	logic        held;          // valid without ready at last edge
	lpc_record_t held_rec;

	lpc_sniffer_top u_lpc_sniffer_top (
		.lpc_clock  (lpc_clock),
		.lpc_reset  (lpc_reset),
		.lpc_ad     (lpc_ad),
		.lpc_frame  (lpc_frame),
		.rec_ready  (rec_ready),
		.rec_valid  (rec_valid),
		.rec        (rec),
		.drop_count (drop_count)
	);

	always #2 lpc_clock = ~lpc_clock; // 4 ns period

	// record port checks on values from before the edge
	always @(posedge lpc_clock) begin
		if (lpc_reset) begin
			if (held) begin
				assert (rec_valid && rec === held_rec) else begin
					errors++;
					$display("[FAIL] rec held: expected %h got %h (rec_valid %h)",
						held_rec, rec, rec_valid);
				end
			end
			if (rec_valid && rec_ready) begin
				assert (exp_q.size() != 0) else begin
					errors++;
					$display("record %h delivered but none was expected", rec);
				end
				if (exp_q.size() != 0) begin
					assert (rec === exp_q[0]) else begin
						errors++;
						$display("[FAIL] rec: expected %h got %h", exp_q[0], rec);
					end
					void'(exp_q.pop_front());
				end
			end
			held     = rec_valid && !rec_ready;
			held_rec = rec;
		end else begin
			held = 1'b0;
		end
	end

	task automatic drive(input logic frame, input logic [3:0] ad);
		@(posedge lpc_clock);
		#1;
		lpc_frame = frame;
		lpc_ad    = ad;
	endtask

	task automatic idle(input int n);
		repeat (n) drive(1'b1, 4'hf);
	endtask

	// start, cycle type, 16 bit port high nibble first
	task automatic header(input logic [3:0] cyc, input logic [15:0] port);
		drive(1'b0, 4'h0);
		drive(1'b1, cyc);
		for (int i = 3; i >= 0; i--)
			drive(1'b1, port[i*4 +: 4]);
	endtask

	// queues the record unless the window filters it or a full queue drops it
	task automatic expect_rec(input logic wr, input logic [15:0] port, input logic [7:0] data);
		lpc_record_t r;
		r = {wr, port, data};
		if ((port & WIN_MASK) != (WIN_BASE & WIN_MASK))
			return; // outside window
		if (!rec_ready && exp_q.size() >= FIFO_DEPTH)
			model_drops++;
		else
			exp_q.push_back(r);
	endtask

	task automatic io_write(input logic [15:0] port, input logic [7:0] data, input bit bad);
		header(4'b0010, port);
		drive(1'b1, data[3:0]); // low nibble first
		drive(1'b1, data[7:4]);
		idle(2); // tar
		drive(1'b1, bad ? lpc_sync_error : lpc_sync_ready);
		idle(2); // peripheral tar
		if (!bad)
			expect_rec(1'b1, port, data);
		idle(2);
	endtask

	task automatic io_read(input logic [15:0] port, input logic [7:0] data,
			input int waits, input bit bad);
		header(4'b0000, port);
		idle(2);
		repeat (waits) drive(1'b1, lpc_sync_long_wait);
		drive(1'b1, bad ? lpc_sync_error : lpc_sync_ready);
		if (!bad) begin
			drive(1'b1, data[3:0]);
			drive(1'b1, data[7:4]);
		end
		idle(2);
		if (!bad)
			expect_rec(1'b0, port, data);
		idle(2);
	endtask

	task automatic mem_read(input logic [31:0] addr);
		drive(1'b0, 4'h0);
		drive(1'b1, 4'b0100);
		for (int i = 7; i >= 0; i--)
			drive(1'b1, addr[i*4 +: 4]);
		idle(2);
		drive(1'b1, 4'b0000);
		drive(1'b1, 4'h5);
		drive(1'b1, 4'ha);
		idle(4);
	endtask

	// stops mid address so the next start aborts it
	task automatic truncated(input logic [15:0] port, input int nibbles);
		drive(1'b0, 4'h0);
		drive(1'b1, 4'b0010);
		for (int i = 0; i < nibbles; i++)
			drive(1'b1, port[(3-i)*4 +: 4]);
	endtask

	function automatic logic [15:0] win_port();
		return WIN_BASE | 16'($urandom % 8);
	endfunction

	function automatic logic [15:0] off_port();
		logic [15:0] p;
		p = 16'($urandom);
		if ((p & WIN_MASK) == (WIN_BASE & WIN_MASK))
			p = p ^ 16'h0100;
		return p;
	endfunction

	task automatic begin_test();
		tests++;
		test_err0 = errors;
	endtask

	// drains the scoreboard with ready held high or toggling at random
	task automatic end_test(input string name, input bit toggle);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < 200) begin
			@(posedge lpc_clock);
			#1;
			rec_ready = toggle ? 1'($urandom % 2) : 1'b1;
			n++;
		end
		rec_ready = 1'b1;
		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d expected records never arrived", exp_q.size());
			exp_q.delete();
		end
		idle(4); // catch stray records
		$display("test %0d %s: %s (%0d errors)", tests, name,
			(errors == test_err0) ? "pass" : "fail", errors - test_err0);
	endtask

	initial begin
		void'($urandom(11242));
		lpc_clock   = 1'b0;
		lpc_reset   = 1'b0;
		lpc_ad      = 4'hf;
		lpc_frame   = 1'b1;
		rec_ready   = 1'b1;
		errors      = 0;
		tests       = 0;
		model_drops = 0;
		held        = 1'b0;
		repeat (10) @(posedge lpc_clock);
		#1;
		lpc_reset = 1'b1;
		idle(2);

		begin_test();
		repeat (4) io_write(win_port(), 8'($urandom), 1'b0);
		end_test("io writes in window", 1'b0);

		begin_test();
		io_read(win_port(), 8'($urandom), 0, 1'b0);
		io_read(win_port(), 8'($urandom), 1, 1'b0);
		io_read(win_port(), 8'($urandom), 3, 1'b0);
		end_test("io reads with wait syncs", 1'b0);

		begin_test();
		io_write(off_port(), 8'($urandom), 1'b0);
		io_read(off_port(), 8'($urandom), 1, 1'b0);
		mem_read({16'h0000, win_port()});
		io_write(win_port(), 8'($urandom), 1'b1); // error sync
		io_read(win_port(), 8'($urandom), 2, 1'b1);
		end_test("filtered and failed cycles", 1'b0);

		begin_test();
		truncated(win_port(), 2);
		io_write(win_port(), 8'($urandom), 1'b0);
		end_test("restart mid address", 1'b0);

		begin_test();
		rec_ready = 1'b0;
		repeat (7) io_write(win_port(), 8'($urandom), 1'b0);
		end_test("back-pressure and drops", 1'b1);

		assert (drop_count === model_drops[7:0] && model_drops == 3) else begin
			errors++;
			$display("[FAIL] drop_count: expected %h got %h", model_drops[7:0], drop_count);
		end
		assert (exp_q.size() == 0) else begin
			errors++;
			$display("scoreboard still holds %0d records at the end", exp_q.size());
		end

		$display("tests %0d, errors %0d", tests, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// bounds the run by the frame budget
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge lpc_clock);
		$display("timeout: run did not complete within %0d cycles", WATCHDOG_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire
